// File: Bender.yml
package:
  name: pixel_sensor

sources:
  - files:
      - hw/sensor_pkg.sv
      - hw/sensor_sequencer.sv
      - hw/pixel_array.sv
      - hw/row_buffer.sv
      - hw/row_serializer.sv
      - hw/sensor_top.sv
  - target: test
    files:
      - verif/sensor_checker.sv
      - verif/tb_sensor_top.sv

// File: hw/pixel_array.sv
`timescale 1ns/1ns

module pixel_array #(
	parameter int array_width = 8,
	parameter int array_height = 4,
	localparam int row_bits = (array_height > 1) ? $clog2(array_height) : 1
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                pixel_erase,
	input  logic                pixel_convert,
	input  sensor_pkg::pixel_t  ramp_gray,
	input  sensor_pkg::pixel_t [array_width*array_height-1:0] scene,
	input  logic [row_bits-1:0] row_index,
	output sensor_pkg::pixel_t [array_width-1:0] row_data
);

	localparam int pixel_count = array_width * array_height;
	localparam sensor_pkg::pixel_t full_scale = {sensor_pkg::pixel_bits{1'b1}};

	logic               captured [pixel_count];
	sensor_pkg::pixel_t code_q [pixel_count];

	for (genvar i = 0; i < pixel_count; i++) begin : g_pixel
		sensor_pkg::pixel_t threshold;
		logic               hit;

		// a bright pixel crosses early, so its threshold is the inverted scene value.
		assign threshold = sensor_pkg::to_gray(full_scale - scene[i]);
		assign hit = pixel_convert && !captured[i] && (ramp_gray == threshold);

		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				captured[i] <= 1'b0;
			end else if (pixel_erase) begin
				captured[i] <= 1'b0;
			end else if (hit) begin
				captured[i] <= 1'b1;
			end
		end

		always_ff @(posedge clk) begin
			if (pixel_erase) begin
				code_q[i] <= '0;
			end else if (hit) begin
				code_q[i] <= ramp_gray; // only the first match is kept.
			end
		end
	end

	always_comb begin
		for (int c = 0; c < array_width; c++) begin
			row_data[c] = code_q[int'(row_index) * array_width + c];
		end
	end

endmodule

// File: hw/row_buffer.sv
`timescale 1ns/1ns

module row_buffer #(
	parameter int array_width = 8
) (
	input  logic clk,
	input  logic reset,
	input  sensor_pkg::pixel_t [array_width-1:0] row_data,
	input  logic row_valid,
	output sensor_pkg::pixel_t [array_width-1:0] buffered_row,
	output logic row_loaded
);

	// the row is held here so the array can move on to the next row select.
	always_ff @(posedge clk) begin
		if (row_valid) begin
			buffered_row <= row_data;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			row_loaded <= 1'b0;
		end else begin
			row_loaded <= row_valid; // new data is visible in buffered_row from this cycle.
		end
	end

endmodule

// File: hw/row_serializer.sv
`timescale 1ns/1ns

module row_serializer #(
	parameter int array_width = 8,
	parameter int bus_pixels = 4
) (
	input  logic clk,
	input  logic reset,
	input  sensor_pkg::pixel_t [array_width-1:0] buffered_row,
	input  logic row_loaded,
	output sensor_pkg::pixel_t [bus_pixels-1:0] pixel_data,
	output logic pixel_valid
);

	localparam int word_count = array_width / bus_pixels;
	localparam int word_bits = (word_count > 1) ? $clog2(word_count) : 1;
	localparam logic [word_bits-1:0] word_last = word_bits'(word_count - 1);

	logic                 busy;
	logic [word_bits-1:0] word_index;
	logic                 emit;
	logic [word_bits-1:0] word_sel;

	// the first word goes out right behind row_loaded.
	assign emit = row_loaded | busy;
	assign word_sel = row_loaded ? '0 : word_index;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			word_index <= '0;
			pixel_valid <= 1'b0;
		end else begin
			pixel_valid <= emit;
			if (emit) begin
				if (word_sel == word_last) begin
					busy <= 1'b0;
					word_index <= '0;
				end else begin
					busy <= 1'b1;
					word_index <= word_sel + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (emit) begin
			for (int p = 0; p < bus_pixels; p++) begin
				pixel_data[p] <= sensor_pkg::from_gray(
					buffered_row[int'(word_sel) * bus_pixels + p]);
			end
		end
	end

endmodule

// File: hw/sensor_pkg.sv
package sensor_pkg;

	localparam int pixel_bits = 8;

	typedef logic [pixel_bits-1:0] pixel_t;

	// one ramp code per convert cycle covers the full pixel range.
	localparam int ramp_steps = 1 << pixel_bits;

	function automatic pixel_t to_gray(input pixel_t bin);
		return bin ^ (bin >> 1);
	endfunction

	function automatic pixel_t from_gray(input pixel_t gray);
		pixel_t bin;
		bin[pixel_bits-1] = gray[pixel_bits-1]; // the top bit is the same in both codes.
		for (int i = pixel_bits - 2; i >= 0; i--) begin
			bin[i] = bin[i+1] ^ gray[i];
		end
		return bin;
	endfunction

endpackage

// File: hw/sensor_sequencer.sv
`timescale 1ns/1ns

module sensor_sequencer #(
	parameter int array_height = 4,
	parameter int erase_cycles = 5,
	parameter int expose_cycles = 16,
	parameter int row_cycles = 6,
	localparam int row_bits = (array_height > 1) ? $clog2(array_height) : 1
) (
	input  logic               clk,
	input  logic               reset,
	output logic               pixel_erase,
	output logic               pixel_convert,
	output sensor_pkg::pixel_t ramp_gray,
	output logic [row_bits-1:0] row_index,
	output logic               row_valid,
	output logic               frame_done
);

	localparam logic [1:0] ph_erase = 2'd0;
	localparam logic [1:0] ph_expose = 2'd1;
	localparam logic [1:0] ph_convert = 2'd2;
	localparam logic [1:0] ph_read = 2'd3;

	localparam int long_timed = (erase_cycles > expose_cycles) ? erase_cycles : expose_cycles;
	localparam int max_len = (long_timed > sensor_pkg::ramp_steps) ?
		long_timed : sensor_pkg::ramp_steps;
	localparam int cnt_bits = $clog2(max_len);
	localparam int slot_bits = $clog2(row_cycles);

	localparam logic [cnt_bits-1:0] erase_last = cnt_bits'(erase_cycles - 1);
	localparam logic [cnt_bits-1:0] expose_last = cnt_bits'(expose_cycles - 1);
	localparam logic [cnt_bits-1:0] convert_last = cnt_bits'(sensor_pkg::ramp_steps - 1);
	localparam logic [slot_bits-1:0] slot_last = slot_bits'(row_cycles - 1);
	localparam logic [row_bits-1:0] row_last = row_bits'(array_height - 1);

	logic [1:0]          phase;
	logic [1:0]          phase_next;
	logic [cnt_bits-1:0] cycle_count;
	logic [cnt_bits-1:0] cycle_next;
	logic [row_bits-1:0] row_count;
	logic [row_bits-1:0] row_next;
	logic [slot_bits-1:0] slot_count;
	logic [slot_bits-1:0] slot_next;

	always_comb begin
		phase_next = phase;
		cycle_next = cycle_count + 1'b1;
		row_next = row_count;
		slot_next = '0;
		case (phase)
			ph_erase: begin
				if (cycle_count == erase_last) begin
					phase_next = ph_expose;
					cycle_next = '0;
				end
			end
			ph_expose: begin
				if (cycle_count == expose_last) begin
					phase_next = ph_convert;
					cycle_next = '0;
				end
			end
			ph_convert: begin
				if (cycle_count == convert_last) begin
					phase_next = ph_read;
					cycle_next = '0;
					row_next = '0;
				end
			end
			default: begin
				cycle_next = '0; // read is timed by the row and slot counters.
				if (slot_count == slot_last) begin
					if (row_count == row_last) begin
						phase_next = ph_erase;
						row_next = '0;
					end else begin
						row_next = row_count + 1'b1;
					end
				end else begin
					slot_next = slot_count + 1'b1;
				end
			end
		endcase
	end

	// reset parks on the final read cycle, so the first edge starts a clean erase.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= ph_read;
			cycle_count <= '0;
			row_count <= row_last;
			slot_count <= slot_last;
		end else begin
			phase <= phase_next;
			cycle_count <= cycle_next;
			row_count <= row_next;
			slot_count <= slot_next;
		end
	end

	// the strobes are decoded from the next state so they line up with the phase register.
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pixel_erase <= 1'b0;
			pixel_convert <= 1'b0;
			row_valid <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			pixel_erase <= (phase_next == ph_erase);
			pixel_convert <= (phase_next == ph_convert);
			row_valid <= (phase_next == ph_read) && (slot_next == '0);
			frame_done <= (phase_next == ph_read) && (slot_next == slot_last) &&
				(row_next == row_last);
		end
	end

	assign ramp_gray = sensor_pkg::to_gray(cycle_count[sensor_pkg::pixel_bits-1:0]);
	assign row_index = row_count;

endmodule

// File: hw/sensor_top.sv
`timescale 1ns/1ns

module sensor_top #(
	parameter int array_width = 8,
	parameter int array_height = 4,
	parameter int bus_pixels = 4,
	parameter int erase_cycles = 5,
	parameter int expose_cycles = 16,
	parameter int row_cycles = 6
) (
	input  logic clk,
	input  logic reset,
	input  sensor_pkg::pixel_t [array_width*array_height-1:0] scene,
	output sensor_pkg::pixel_t [bus_pixels-1:0] pixel_data,
	output logic pixel_valid,
	output logic frame_done
);

	localparam int row_bits = (array_height > 1) ? $clog2(array_height) : 1;

	logic                pixel_erase;
	logic                pixel_convert;
	sensor_pkg::pixel_t  ramp_gray;
	logic [row_bits-1:0] row_index;
	logic                row_valid;
	logic                row_loaded;
	sensor_pkg::pixel_t [array_width-1:0] row_data;
	sensor_pkg::pixel_t [array_width-1:0] buffered_row;

	sensor_sequencer #(
		.array_height (array_height),
		.erase_cycles (erase_cycles),
		.expose_cycles(expose_cycles),
		.row_cycles   (row_cycles)
	) u_sensor_sequencer (
		.clk          (clk),
		.reset        (reset),
		.pixel_erase  (pixel_erase),
		.pixel_convert(pixel_convert),
		.ramp_gray    (ramp_gray),
		.row_index    (row_index),
		.row_valid    (row_valid),
		.frame_done   (frame_done)
	);

	pixel_array #(
		.array_width (array_width),
		.array_height(array_height)
	) u_pixel_array (
		.clk          (clk),
		.reset        (reset),
		.pixel_erase  (pixel_erase),
		.pixel_convert(pixel_convert),
		.ramp_gray    (ramp_gray),
		.scene        (scene),
		.row_index    (row_index),
		.row_data     (row_data)
	);

	row_buffer #(
		.array_width(array_width)
	) u_row_buffer (
		.clk         (clk),
		.reset       (reset),
		.row_data    (row_data),
		.row_valid   (row_valid),
		.buffered_row(buffered_row),
		.row_loaded  (row_loaded)
	);

	row_serializer #(
		.array_width(array_width),
		.bus_pixels (bus_pixels)
	) u_row_serializer (
		.clk         (clk),
		.reset       (reset),
		.buffered_row(buffered_row),
		.row_loaded  (row_loaded),
		.pixel_data  (pixel_data),
		.pixel_valid (pixel_valid)
	);

endmodule

// File: pixel_sensor.f
hw/sensor_pkg.sv
hw/sensor_sequencer.sv
hw/pixel_array.sv
hw/row_buffer.sv
hw/row_serializer.sv
hw/sensor_top.sv
verif/sensor_checker.sv
verif/tb_sensor_top.sv

// File: verif/sensor_checker.sv
`timescale 1ns/1ns

module sensor_checker #(
	parameter int array_width = 8,
	parameter int array_height = 4,
	parameter int bus_pixels = 4,
	parameter int frame_period = 301
) (
	input  logic clk,
	input  logic reset,
	input  sensor_pkg::pixel_t [array_width*array_height-1:0] scene,
	input  sensor_pkg::pixel_t [bus_pixels-1:0] pixel_data,
	input  logic pixel_valid,
	input  logic frame_done,
	output int   error_count,
	output int   check_count,
	output int   frame_count
);

	localparam int words_per_row = array_width / bus_pixels;
	localparam int words_per_frame = words_per_row * array_height;

	sensor_pkg::pixel_t [array_width*array_height-1:0] frame_scene;
	logic latch_pending = 1'b1;
	logic in_reset = 1'b1;
	int   cycle = 0;
	int   last_done = 0;
	int   word_index = 0;
	int   errors = 0;
	int   checks = 0;
	int   frames = 0;

	// a pixel that sees full brightness crosses the ramp first and reads out as 0.
	function automatic sensor_pkg::pixel_t expected_pixel(
		input sensor_pkg::pixel_t [array_width*array_height-1:0] image,
		input int row,
		input int col);
		return sensor_pkg::pixel_t'(255 - int'(image[row * array_width + col]));
	endfunction

	always @(posedge clk) begin : compare
		int row;
		int col;
		sensor_pkg::pixel_t expect_value;
		cycle++;
		if (reset) begin
			if (pixel_valid) begin
				$display("CHECK FAILED pixel_valid during reset: expected %h, got %h",
					1'b0, pixel_valid);
				errors++;
			end
			if (frame_done) begin
				$display("CHECK FAILED frame_done during reset: expected %h, got %h",
					1'b0, frame_done);
				errors++;
			end
			in_reset = 1'b1;
			latch_pending = 1'b1;
			word_index = 0;
		end else begin
			if (in_reset) begin
				last_done = cycle; // the first cycle out of reset acts like a frame_done.
				in_reset = 1'b0;
			end
			if (latch_pending) begin
				frame_scene = scene; // the scene for the frame that starts here.
				latch_pending = 1'b0;
			end
			if (pixel_valid) begin
				if (word_index >= words_per_frame) begin
					$display("ERROR: more output words than one frame holds");
					errors++;
				end else begin
					row = word_index / words_per_row;
					for (int p = 0; p < bus_pixels; p++) begin
						col = (word_index % words_per_row) * bus_pixels + p;
						expect_value = expected_pixel(frame_scene, row, col);
						checks++;
						if (pixel_data[p] !== expect_value) begin
							$display("CHECK FAILED pixel_data[%0d] at %0d,%0d: expected %h, got %h",
								p, row, col, expect_value, pixel_data[p]);
							errors++;
						end
					end
				end
				word_index++;
			end
			if (frame_done) begin
				checks += 2;
				if (word_index != words_per_frame) begin
					$display("CHECK FAILED pixel_valid words per frame: expected %h, got %h",
						words_per_frame, word_index);
					errors++;
				end
				if (cycle - last_done != frame_period) begin
					$display("CHECK FAILED frame_done period: expected %h, got %h",
						frame_period, cycle - last_done);
					errors++;
				end
				last_done = cycle;
				word_index = 0;
				frames++;
				latch_pending = 1'b1;
			end
		end
		error_count <= errors;
		check_count <= checks;
		frame_count <= frames;
	end

endmodule

// File: verif/tb_sensor_top.sv
`timescale 1ns/1ns

module tb_sensor_top;

	localparam int array_width = 8;
	localparam int array_height = 4;
	localparam int bus_pixels = 4;
	localparam int erase_cycles = 5;
	localparam int expose_cycles = 16;
	localparam int row_cycles = 6;
	localparam int pixel_count = array_width * array_height;
	localparam int frame_period = erase_cycles + expose_cycles + sensor_pkg::ramp_steps +
		array_height * row_cycles;
	localparam int wait_limit = 2 * frame_period;

	localparam int scene_random = 0;
	localparam int scene_ramp = 1;
	localparam int scene_dark = 2;
	localparam int scene_bright = 3;

	logic clk;
	logic reset;
	sensor_pkg::pixel_t [pixel_count-1:0] scene;
	sensor_pkg::pixel_t [bus_pixels-1:0] pixel_data;
	logic pixel_valid;
	logic frame_done;
	int   error_count;
	int   check_count;
	int   frame_count;
	int   tests_run = 0;
	int   tests_failed = 0;
	int   errors_before = 0;
	logic timed_out = 1'b0;

	sensor_top #(
		.array_width  (array_width),
		.array_height (array_height),
		.bus_pixels   (bus_pixels),
		.erase_cycles (erase_cycles),
		.expose_cycles(expose_cycles),
		.row_cycles   (row_cycles)
	) u_sensor_top (
		.clk        (clk),
		.reset      (reset),
		.scene      (scene),
		.pixel_data (pixel_data),
		.pixel_valid(pixel_valid),
		.frame_done (frame_done)
	);

	sensor_checker #(
		.array_width (array_width),
		.array_height(array_height),
		.bus_pixels  (bus_pixels),
		.frame_period(frame_period)
	) u_sensor_checker (
		.clk        (clk),
		.reset      (reset),
		.scene      (scene),
		.pixel_data (pixel_data),
		.pixel_valid(pixel_valid),
		.frame_done (frame_done),
		.error_count(error_count),
		.check_count(check_count),
		.frame_count(frame_count)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic load_scene(input int kind);
		sensor_pkg::pixel_t [pixel_count-1:0] image;
		for (int i = 0; i < pixel_count; i++) begin
			case (kind)
				scene_ramp: image[i] = sensor_pkg::pixel_t'(i * 37 + 11); // distinct per position.
				scene_dark: image[i] = '0;
				scene_bright: image[i] = '1;
				default: image[i] = sensor_pkg::pixel_t'($urandom);
			endcase
		end
		scene <= image;
	endtask

	task automatic wait_frame_done();
		int waited;
		waited = 0;
		if (timed_out) begin
			return;
		end
		@(posedge clk);
		while (!frame_done && waited < wait_limit) begin
			@(posedge clk);
			waited++;
		end
		if (!frame_done) begin
			$display("Timed out after %0d cycles waiting for frame_done", wait_limit);
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_pixel_valid();
		int waited;
		waited = 0;
		if (timed_out) begin
			return;
		end
		@(posedge clk);
		while (!pixel_valid && waited < wait_limit) begin
			@(posedge clk);
			waited++;
		end
		if (!pixel_valid) begin
			$display("Timed out after %0d cycles waiting for pixel_valid", wait_limit);
			timed_out = 1'b1;
		end
	endtask

	// the next frame's scene goes in right after frame_done.
	task automatic finish_frame(input int next_kind);
		wait_frame_done();
		if (!timed_out) begin
			load_scene(next_kind);
		end
	endtask

	task automatic report_test(input int number, input string name);
		int found;
		@(negedge clk); // the checker's counts have settled by now.
		found = error_count - errors_before;
		tests_run++;
		if (found != 0) begin
			tests_failed++;
		end
		$display("test %0d %s: %s, %0d errors", number, name, (found == 0) ? "ok" : "failed",
			found);
		errors_before = error_count;
	endtask

	// the sequence stops at the first wait that runs out of time.
	task automatic run_tests();
		finish_frame(scene_random);
		finish_frame(scene_random);
		finish_frame(scene_ramp);
		if (timed_out) begin
			return;
		end
		report_test(1, "pixel values");

		finish_frame(scene_random);
		if (timed_out) begin
			return;
		end
		report_test(2, "word order");

		finish_frame(scene_dark);
		if (timed_out) begin
			return;
		end
		report_test(3, "frame count and strobe");

		finish_frame(scene_bright);
		finish_frame(scene_random);
		if (timed_out) begin
			return;
		end
		report_test(4, "extremes");

		wait_pixel_valid(); // the frame is now in its read phase.
		if (timed_out) begin
			return;
		end
		repeat (2) @(posedge clk);
		reset <= 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		finish_frame(scene_random);
		if (timed_out) begin
			return;
		end
		report_test(5, "reset");
	endtask

	initial begin
		void'($urandom(32'h77ce_d1c6));
		reset = 1'b1;
		load_scene(scene_random);
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		run_tests();

		if (check_count == 0) begin
			$display("ERROR: no output word was checked");
		end
		$display("tests run %0d, tests failed %0d, frames %0d, checks %0d, errors %0d",
			tests_run, tests_failed, frame_count, check_count, error_count);
		if (!timed_out && error_count == 0 && tests_failed == 0 && check_count > 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule
